//--- files.f
+incdir+hdl
hdl/patch_pkg.sv
hdl/patch_sequencer.sv
hdl/patch_fifo.sv
hdl/patch_stream_top.sv
tb/patch_stream_tb.sv

//--- hdl/patch_defs.svh
`ifndef PATCH_DEFS_SVH
`define PATCH_DEFS_SVH

// Stream geometry
`define N_CAM            3
`define LFSR_WIDTH       6        // Taps at 6 and 5, period 63
`define PATCH_NUM_WIDTH  10
`define FP_WIDTH         14
`define WORD_WIDTH       24       // Patch number plus coordinate
`define N_PATCH          256      // Patches per frame
`define GAP_CYCLES       4        // Idle cycles between frames
`define FIFO_DEPTH       16

// Per-camera LFSR seeds
`define SEED0            6'd8
`define SEED1            6'd16
`define SEED2            6'd32

// Reserved patch numbers for the frame markers
`define SOF_NUM          10'd1023
`define EOF_NUM          10'd1022

`endif

//--- hdl/patch_fifo.sv
`timescale 1ns/1ps
`include "patch_defs.svh"

module patch_fifo (
  input  logic                   clk_200,
  input  logic                   arst_n,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  patch_pkg::patch_word_u din,
  output patch_pkg::patch_word_u dout,
  output logic                   full,
  output logic                   empty
);
  import patch_pkg::*;

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);   // Depth is a power of 2 so pointers wrap naturally
  localparam int CNT_W = PTR_W + 1;

  patch_word_u      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;          // Pop on empty is dropped

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];              // Show-ahead head word

  always_ff @(posedge clk_200) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk_200 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Both or neither
      endcase
    end
  end

  // Sequencer must stop writing before the buffer overflows
  a_no_write_full : assert property (
    @(posedge clk_200) disable iff (!arst_n) full |-> !wr_en);

  c_read_empty : cover property (
    @(posedge clk_200) disable iff (!arst_n) rd_en && empty);

endmodule

//--- hdl/patch_pkg.sv
`include "patch_defs.svh"

package patch_pkg;

  // Data view of a record word
  typedef struct packed {
    logic [`PATCH_NUM_WIDTH-1:0] patch_num;
    logic [`FP_WIDTH-1:0]        fp;          // Fixed-point coordinate
  } patch_data_t;

  // Marker view, used for SOF and EOF words
  typedef struct packed {
    logic [`PATCH_NUM_WIDTH-1:0]             marker_id;
    logic [`WORD_WIDTH-`PATCH_NUM_WIDTH-1:0] marker_pad;  // Always zero
  } patch_marker_t;

  // One word, decoded as data or as a marker
  typedef union packed {
    patch_data_t   data;
    patch_marker_t marker;
  } patch_word_u;

  // Frame sequencer states
  typedef enum logic [2:0] {
    INIT, GAP, SOF, INTRA, EOF, ERROR
  } seq_state_e;

endpackage

//--- hdl/patch_sequencer.sv
`timescale 1ns/1ps
`include "patch_defs.svh"

module patch_sequencer (
  input  logic                   clk_200,
  input  logic                   arst_n,
  input  logic                   app_ready,
  input  logic [`N_CAM-1:0]      fifo_full,
  output logic                   wr_en,
  output patch_pkg::patch_word_u word0,
  output patch_pkg::patch_word_u word1,
  output patch_pkg::patch_word_u word2,
  output logic                   stream_error
);
  import patch_pkg::*;

  localparam int PASS_LEN  = (1 << `LFSR_WIDTH) - 1;       // One full LFSR period
  localparam int LAST_MIN  = `N_PATCH - (1 << `LFSR_WIDTH); // Offset above this ends frame
  localparam int GAP_CNT_W = $clog2(`GAP_CYCLES);
  localparam logic [`LFSR_WIDTH-1:0] SEED [`N_CAM] = '{`SEED0, `SEED1, `SEED2};

  logic [1:0]                  ready_sync;
  logic                        ready_s;
  seq_state_e                  state;
  logic [GAP_CNT_W-1:0]        gap_cnt;
  logic [`LFSR_WIDTH-1:0]      word_cnt;   // Position inside the current pass
  logic [`PATCH_NUM_WIDTH-1:0] offset;     // Patch number offset of the pass
  logic [`LFSR_WIDTH-1:0]      lfsr [`N_CAM];
  logic                        in_frame;
  logic                        frame_fault;
  logic                        pass_done;
  patch_word_u                 word [`N_CAM];

  function automatic logic [`LFSR_WIDTH-1:0] lfsr_step(input logic [`LFSR_WIDTH-1:0] v);
    return {v[`LFSR_WIDTH-2:0], ~(v[`LFSR_WIDTH-1] ^ v[`LFSR_WIDTH-2])};
  endfunction

  always_ff @(posedge clk_200 or negedge arst_n) begin
    if (!arst_n) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[0], app_ready}; // Two-flop synchronizer
    end
  end

  assign ready_s = ready_sync[1];

  assign in_frame    = (state == SOF) || (state == INTRA) || (state == EOF);
  assign frame_fault = in_frame && (!ready_s || (|fifo_full));
  assign wr_en       = in_frame && !frame_fault;
  assign pass_done   = (word_cnt == `LFSR_WIDTH'(PASS_LEN - 1));
  assign stream_error = (state == ERROR);

  always_ff @(posedge clk_200 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= INIT;
      gap_cnt  <= '0;
      word_cnt <= '0;
      offset   <= '0;
    end else begin
      case (state)
        INIT: begin
          if (ready_s) begin
            state <= GAP;
          end
        end
        GAP: begin
          if (gap_cnt == GAP_CNT_W'(`GAP_CYCLES - 1)) begin
            gap_cnt  <= '0;
            word_cnt <= '0;
            offset   <= '0;
            state    <= SOF;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        SOF: begin
          state <= frame_fault ? ERROR : INTRA;
        end
        INTRA: begin
          if (frame_fault) begin
            state <= ERROR;
          end else if (pass_done) begin
            word_cnt <= '0;
            if (offset > LAST_MIN) begin
              state <= EOF;                      // Last pass written
            end else begin
              offset <= offset + `PATCH_NUM_WIDTH'(PASS_LEN);
            end
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end
        EOF: begin
          state <= frame_fault ? ERROR : GAP;
        end
        default: begin
          state <= ERROR;                        // Sticky until reset
        end
      endcase
    end
  end

  // LFSRs hold the seed outside INTRA and restart at every pass boundary
  always_ff @(posedge clk_200 or negedge arst_n) begin
    if (!arst_n) begin
      for (int c = 0; c < `N_CAM; c++) begin
        lfsr[c] <= SEED[c];
      end
    end else begin
      for (int c = 0; c < `N_CAM; c++) begin
        if (state != INTRA || pass_done) begin
          lfsr[c] <= SEED[c];
        end else begin
          lfsr[c] <= lfsr_step(lfsr[c]);
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < `N_CAM; c++) begin
      word[c] = '0;
      if (state == SOF) begin
        word[c].marker.marker_id = `SOF_NUM;
      end else if (state == EOF) begin
        word[c].marker.marker_id = `EOF_NUM;
      end else begin
        word[c].data.patch_num = offset + `PATCH_NUM_WIDTH'(lfsr[c]);
        word[c].data.fp = {lfsr[c][`LFSR_WIDTH-1], 4'b1000,
                           lfsr[c][`LFSR_WIDTH-2:0], 4'b0000};
      end
    end
  end

  assign word0 = word[0];
  assign word1 = word[1];
  assign word2 = word[2];

  // A full buffer seen inside a frame ends the stream
  a_full_to_error : assert property (
    @(posedge clk_200) disable iff (!arst_n) (in_frame && (|fifo_full)) |=> stream_error);

  a_error_sticky : assert property (
    @(posedge clk_200) disable iff (!arst_n) $past(stream_error) |-> stream_error);

  a_state_legal : assert property (
    @(posedge clk_200) disable iff (!arst_n)
    state inside {INIT, GAP, SOF, INTRA, EOF, ERROR});

endmodule

//--- hdl/patch_stream_top.sv
`timescale 1ns/1ps
`include "patch_defs.svh"

module patch_stream_top (
  input  logic                   clk_200,
  input  logic                   arst_n,
  input  logic                   app_ready,
  input  logic [`N_CAM-1:0]      rd_en,
  output patch_pkg::patch_word_u cam0_word,
  output patch_pkg::patch_word_u cam1_word,
  output patch_pkg::patch_word_u cam2_word,
  output logic [`N_CAM-1:0]      empty,
  output logic                   stream_error
);
  import patch_pkg::*;

  logic              wr_en;      // Shared by all cameras
  logic [`N_CAM-1:0] fifo_full;
  patch_word_u       word0;
  patch_word_u       word1;
  patch_word_u       word2;
  patch_word_u       fifo_din  [`N_CAM];
  patch_word_u       fifo_dout [`N_CAM];

  patch_sequencer i_seq (
    .clk_200      (clk_200),
    .arst_n       (arst_n),
    .app_ready    (app_ready),
    .fifo_full    (fifo_full),
    .wr_en        (wr_en),
    .word0        (word0),
    .word1        (word1),
    .word2        (word2),
    .stream_error (stream_error)
  );

  assign fifo_din[0] = word0;
  assign fifo_din[1] = word1;
  assign fifo_din[2] = word2;

  // One buffer per camera stream
  generate
    for (genvar c = 0; c < `N_CAM; c++) begin : g_cam
      patch_fifo i_fifo (
        .clk_200 (clk_200),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .rd_en   (rd_en[c]),
        .din     (fifo_din[c]),
        .dout    (fifo_dout[c]),
        .full    (fifo_full[c]),
        .empty   (empty[c])
      );
    end
  endgenerate

  assign cam0_word = fifo_dout[0];
  assign cam1_word = fifo_dout[1];
  assign cam2_word = fifo_dout[2];

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the patch stream testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module patch_stream_tb \
  -f files.f \
  -o sim_patch_stream

./obj_dir/sim_patch_stream 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi
echo "Simulation finished without errors"

//--- tb/patch_cases.txt
# id frames drain_mode stall_cycle ready_drop_cycle exp_error exp_frames
# Cycles count clock edges after app_ready rises, 0 turns the event off
1 1 0 0   0   0 1
2 3 0 0   0   0 3
3 2 1 0   0   0 2
4 2 0 100 0   1 0
5 2 0 0   150 1 0
# Ready falls inside the first inter-frame gap and is caught at the next SOF
6 2 0 0   324 1 1
7 1 1 200 0   1 0

//--- tb/patch_stream_tb.sv
`timescale 1ns/1ps
`include "patch_defs.svh"

module patch_stream_tb;
  import patch_pkg::*;

  localparam int PASS_LEN = (1 << `LFSR_WIDTH) - 1;

  logic              clk_200;
  logic              arst_n;
  logic              app_ready;
  logic [`N_CAM-1:0] rd_en;
  patch_word_u       cam0_word;
  patch_word_u       cam1_word;
  patch_word_u       cam2_word;
  logic [`N_CAM-1:0] empty;
  logic              stream_error;

  integer seed = 32'h12ba;
  int     data_len;               // Data words per frame
  int     pos [`N_CAM];           // Index of the next expected word in the frame
  int     frames [`N_CAM];        // Complete frames received
  int     late_pops [`N_CAM];     // Pops after stream_error was seen

  patch_stream_top i_dut (
    .clk_200      (clk_200),
    .arst_n       (arst_n),
    .app_ready    (app_ready),
    .rd_en        (rd_en),
    .cam0_word    (cam0_word),
    .cam1_word    (cam1_word),
    .cam2_word    (cam2_word),
    .empty        (empty),
    .stream_error (stream_error)
  );

  initial begin
    clk_200 = 1'b0;
    forever #10 clk_200 = ~clk_200;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Passes continue until the offset of the pass just written is above N_PATCH - 64
  function automatic int frame_data_len();
    int off;
    int n;
    off = 0;
    n = 1;
    while (off <= `N_PATCH - (1 << `LFSR_WIDTH)) begin
      off = off + PASS_LEN;
      n = n + 1;
    end
    return n * PASS_LEN;
  endfunction

  function automatic logic [`WORD_WIDTH-1:0] expected_word(input int cam, input int idx);
    logic [`LFSR_WIDTH-1:0] v;
    int                     k;
    if (idx == 0) return {`SOF_NUM, {`FP_WIDTH{1'b0}}};
    if (idx == data_len + 1) return {`EOF_NUM, {`FP_WIDTH{1'b0}}};
    v = (cam == 0) ? `SEED0 : (cam == 1) ? `SEED1 : `SEED2;
    for (k = 0; k < (idx - 1) % PASS_LEN; k++) begin
      v = {v[`LFSR_WIDTH-2:0], ~(v[`LFSR_WIDTH-1] ^ v[`LFSR_WIDTH-2])};
    end
    return {`PATCH_NUM_WIDTH'((idx - 1) / PASS_LEN * PASS_LEN) + `PATCH_NUM_WIDTH'(v),
            v[`LFSR_WIDTH-1], 4'b1000, v[`LFSR_WIDTH-2:0], 4'b0000};
  endfunction

  function automatic logic [`WORD_WIDTH-1:0] head_word(input int cam);
    case (cam)
      0:       return cam0_word;
      1:       return cam1_word;
      default: return cam2_word;
    endcase
  endfunction

  // Compares the head word that is popped on the next edge, then advances the model
  task automatic check_pop(input int cam);
    patch_word_u            got;
    logic [`WORD_WIDTH-1:0] exp;
    got = head_word(cam);
    exp = expected_word(cam, pos[cam]);
    if (got.marker.marker_id == `SOF_NUM || got.marker.marker_id == `EOF_NUM) begin
      assert (got.marker.marker_pad == '0) else
        stop_run($sformatf("** Error at %0d ns: cam%0d_word.marker_pad expected 0, got %h",
                           $time, cam, got.marker.marker_pad));
    end
    if (pos[cam] != 0 && pos[cam] <= data_len) begin
      assert (got.data.patch_num < `EOF_NUM) else
        stop_run($sformatf("Data word %0d of camera %0d carries a reserved patch number",
                           pos[cam], cam));
    end
    assert (got == exp) else
      stop_run($sformatf("** Error at %0d ns: cam%0d_word expected %h, got %h",
                         $time, cam, exp, got));
    if (pos[cam] == data_len + 1) begin
      pos[cam] = 0;
      frames[cam]++;
    end else begin
      pos[cam]++;
    end
  endtask

  task automatic run_case(input int id, n_frames, mode, stall_cyc, drop_cyc,
                          exp_err, exp_frames);
    int              k;
    int              limit;
    int              quiet;
    int              err_age;
    bit              done;
    bit [`N_CAM-1:0] allow;
    limit   = n_frames * 400 + 200;
    k       = 0;
    quiet   = 0;
    err_age = -1;                 // Below zero until stream_error rises
    done    = 1'b0;
    $display("Case %0d: %0d frames, drain mode %0d, stall %0d, ready drop %0d",
             id, n_frames, mode, stall_cyc, drop_cyc);
    for (int c = 0; c < `N_CAM; c++) begin
      pos[c]       = 0;
      frames[c]    = 0;
      late_pops[c] = 0;
    end
    @(posedge clk_200);
    #2;
    arst_n    = 1'b0;
    app_ready = 1'b0;
    rd_en     = '0;
    repeat (10) @(posedge clk_200);
    #2;
    arst_n = 1'b1;
    repeat (8) begin              // Nothing may move before the consumer is ready
      @(posedge clk_200);
      #2;
      assert (empty == '1) else
        stop_run($sformatf("** Error at %0d ns: empty expected 111, got %b", $time, empty));
      assert (stream_error == 1'b0) else
        stop_run($sformatf("** Error at %0d ns: stream_error expected 0, got 1", $time));
    end
    app_ready = 1'b1;
    while (!done) begin
      @(posedge clk_200);
      #2;
      k++;
      assert (k <= limit) else
        stop_run($sformatf("Case %0d did not finish within %0d cycles", id, limit));
      if (drop_cyc != 0 && k >= drop_cyc) app_ready = 1'b0;
      if (err_age >= 0) begin
        assert (stream_error) else
          stop_run($sformatf("** Error at %0d ns: stream_error expected 1, got 0", $time));
        err_age++;
      end else if (stream_error) begin
        err_age = 0;
      end
      for (int c = 0; c < `N_CAM; c++) begin
        allow[c] = (mode == 0) || (($random(seed) & 63) != 0);
        if (stall_cyc != 0 && k >= stall_cyc && err_age < 10) allow[c] = 1'b0; // Resume to drain
        rd_en[c] = allow[c] && !empty[c];
        if (rd_en[c]) begin
          check_pop(c);
          if (err_age >= 0) late_pops[c]++;
        end
        assert (late_pops[c] <= `FIFO_DEPTH) else
          stop_run($sformatf("Camera %0d kept delivering words after the error", c));
      end
      quiet = (empty == '1) ? quiet + 1 : 0;
      done  = (frames[0] >= n_frames && frames[1] >= n_frames && frames[2] >= n_frames) ||
              (err_age > 10 && quiet >= 20);
    end
    rd_en = '0;
    assert (stream_error == 1'(exp_err)) else
      stop_run($sformatf("** Error at %0d ns: stream_error expected %0d, got %0d",
                         $time, exp_err, stream_error));
    for (int c = 0; c < `N_CAM; c++) begin
      assert (frames[c] == exp_frames) else
        stop_run($sformatf("** Error at %0d ns: cam%0d frame count expected %0d, got %0d",
                           $time, c, exp_frames, frames[c]));
    end
  endtask

  initial begin
    int    fd;
    int    n_cases;
    string line;
    int    id;
    int    n_frames;
    int    mode;
    int    stall_cyc;
    int    drop_cyc;
    int    exp_err;
    int    exp_frames;
    arst_n    = 1'b0;
    app_ready = 1'b0;
    rd_en     = '0;
    n_cases   = 0;
    data_len  = frame_data_len();
    fd = $fopen("tb/patch_cases.txt", "r");
    if (fd == 0) stop_run("Could not open the case file tb/patch_cases.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%d %d %d %d %d %d %d", id, n_frames, mode, stall_cyc,
                    drop_cyc, exp_err, exp_frames) == 7) begin  // Comment lines do not parse
          run_case(id, n_frames, mode, stall_cyc, drop_cyc, exp_err, exp_frames);
          n_cases++;
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      stop_run("No test case was read from the case file");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
